// File: design/branch_resolver.sv
`timescale 1ns/100ps
`include "rv_id_cfg.svh"

module branch_resolver (
    input  logic                slot_valid,
    input  pipe_pkg::fetch_t    slot_data,
    input  pipe_pkg::rd_data_t  rd_data,
    output pipe_pkg::redirect_t next_redirect
);

    logic                taken;
    logic [`RV_XLEN-1:0] target;
    logic [`RV_XLEN-1:0] fall_thru;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;

    assign a         = rd_data.rs1_data;
    assign b         = rd_data.rs2_data;
    assign target    = slot_data.pc + isa_pkg::imm_b(slot_data.inst);
    assign fall_thru = slot_data.pc + `RV_PC_STEP;

    // ------------------------------
    // Condition by funct3
    // ------------------------------
    always_comb begin
        case (slot_data.inst.b.funct3)
            3'b000:  taken = (a == b);                    // BEQ
            3'b001:  taken = (a != b);                    // BNE
            3'b100:  taken = ($signed(a) < $signed(b));   // BLT
            3'b101:  taken = ($signed(a) >= $signed(b));  // BGE
            3'b110:  taken = (a < b);                     // BLTU
            3'b111:  taken = (a >= b);                    // BGEU
            default: taken = 1'b0;
        endcase
    end

    // Compare outcome with the fetch prediction
    always_comb begin
        next_redirect = '0;
        if (slot_valid && slot_data.inst.b.opcode == isa_pkg::OP_BRANCH) begin
            if (taken) begin
                if (!slot_data.prediction_valid || slot_data.predicted_pc != target) begin
                    next_redirect.valid  = 1'b1;
                    next_redirect.target = target;
                end
            end else if (slot_data.prediction_valid) begin
                next_redirect.valid  = 1'b1;  // Predicted taken, falls through
                next_redirect.target = fall_thru;
            end
        end
    end

endmodule

// File: design/decode_out_reg.sv
`timescale 1ns/100ps

module decode_out_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                slot_valid,
    input  pipe_pkg::id_ex_t    next_id,
    input  pipe_pkg::redirect_t next_redirect,
    output logic                adv,
    output logic                out_valid,
    output pipe_pkg::id_ex_t    out_data,
    input  logic                out_ready,
    output pipe_pkg::redirect_t redirect
);

    // Load when empty or the current item is taken
    assign adv = slot_valid && (!out_valid || out_ready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            redirect  <= '0;
        end else if (flush) begin
            out_valid      <= 1'b0;
            redirect.valid <= 1'b0;
        end else if (adv) begin
            out_valid <= 1'b1;
            out_data  <= next_id;
            redirect  <= next_redirect;  // Pulse only on load
        end else begin
            redirect.valid <= 1'b0;      // No repeat while held
            if (out_ready)
                out_valid <= 1'b0;
        end
    end

endmodule

// File: design/fetch_slot.sv
`timescale 1ns/100ps

module fetch_slot (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             in_valid,
    input  pipe_pkg::fetch_t in_data,
    output logic             in_ready,
    input  logic             adv,
    output logic             slot_valid,
    output pipe_pkg::fetch_t slot_data
);

    logic take;

    // Room when empty or when the held item leaves this cycle
    assign in_ready = !slot_valid || adv;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_valid <= 1'b0;
            slot_data  <= '0;
        end else if (flush) begin
            slot_valid <= 1'b0;  // Wrong-path item dropped
        end else if (take) begin
            slot_valid <= 1'b1;
            slot_data  <= in_data;
        end else if (adv) begin
            slot_valid <= 1'b0;
        end
    end

endmodule

// File: design/id_stage.sv
`timescale 1ns/100ps

module id_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                in_valid,
    input  pipe_pkg::fetch_t    in_data,
    output logic                in_ready,
    input  pipe_pkg::wb_t       wb,
    output logic                out_valid,
    output pipe_pkg::id_ex_t    out_data,
    input  logic                out_ready,
    output pipe_pkg::redirect_t redirect
);

    logic                slot_valid;
    pipe_pkg::fetch_t    slot_data;
    logic                adv;
    pipe_pkg::rd_req_t   rd_req;
    pipe_pkg::rd_data_t  rd_data;
    pipe_pkg::id_ex_t    next_id;
    pipe_pkg::redirect_t next_redirect;

    // ------------------------------
    // Input side
    // ------------------------------
    fetch_slot slot_i (
        .clk, .rst, .flush, .in_valid, .in_data, .in_ready,
        .adv, .slot_valid, .slot_data
    );

    // ------------------------------
    // Decode, operands, branch check
    // ------------------------------
    reg_file rf_i (.clk, .rst, .wb, .rd_req, .rd_data);

    inst_decoder dec_i (.slot_data, .rd_req, .rd_data, .next_id);

    branch_resolver br_i (.slot_valid, .slot_data, .rd_data, .next_redirect);

    // Output register toward execute
    decode_out_reg out_i (
        .clk, .rst, .flush, .slot_valid, .next_id, .next_redirect,
        .adv, .out_valid, .out_data, .out_ready, .redirect
    );

endmodule

// File: design/inst_decoder.sv
`timescale 1ns/100ps
`include "rv_id_cfg.svh"

module inst_decoder (
    input  pipe_pkg::fetch_t   slot_data,
    output pipe_pkg::rd_req_t  rd_req,
    input  pipe_pkg::rd_data_t rd_data,
    output pipe_pkg::id_ex_t   next_id
);

    isa_pkg::inst_u      inst;
    logic [`RV_XLEN-1:0] imm;
    pipe_pkg::ctrl_t     ctrl;

    assign inst = slot_data.inst;

    // Source indices sit at the same bits in every format
    assign rd_req.rs1 = inst.r.rs1;
    assign rd_req.rs2 = inst.r.rs2;

    // ------------------------------
    // Immediate select
    // ------------------------------
    always_comb begin
        case (inst.r.opcode)
            isa_pkg::OP_LUI, isa_pkg::OP_AUIPC:
                imm = {inst.u.imm, 12'b0};
            isa_pkg::OP_JAL:
                imm = {{(`RV_XLEN-20){inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
                       inst.j.imm10_1, 1'b0};
            isa_pkg::OP_JALR, isa_pkg::OP_LOAD, isa_pkg::OP_IMM:
                imm = {{(`RV_XLEN-12){inst.i.imm[11]}}, inst.i.imm};
            isa_pkg::OP_STORE:
                imm = {{(`RV_XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            isa_pkg::OP_BRANCH:
                imm = isa_pkg::imm_b(inst);
            default:
                imm = '0;
        endcase
    end

    // ------------------------------
    // Control decode
    // ------------------------------
    always_comb begin
        ctrl = '0;  // ALU_ADD, BR_NONE, MEM_BYTE
        case (inst.r.opcode)
            isa_pkg::OP_LUI: begin
                ctrl.alu_op       = isa_pkg::ALU_LUI;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.reg_write    = 1'b1;
            end
            isa_pkg::OP_AUIPC: begin
                ctrl.alu_op       = isa_pkg::ALU_AUIPC;
                ctrl.alu_src1_pc  = 1'b1;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.reg_write    = 1'b1;
            end
            isa_pkg::OP_JAL: begin
                ctrl.alu_src1_pc  = 1'b1;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.is_jump      = 1'b1;
                ctrl.reg_write    = 1'b1;
            end
            isa_pkg::OP_JALR: begin
                ctrl.alu_src2_imm = 1'b1;  // rs1 + imm
                ctrl.is_jump      = 1'b1;
                ctrl.reg_write    = 1'b1;
            end
            isa_pkg::OP_BRANCH: begin
                ctrl.alu_src1_pc  = 1'b1;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.is_branch    = 1'b1;
                case (inst.b.funct3)
                    3'b000:  ctrl.branch_type = isa_pkg::BR_EQ;
                    3'b001:  ctrl.branch_type = isa_pkg::BR_NE;
                    3'b100:  ctrl.branch_type = isa_pkg::BR_LT;
                    3'b101:  ctrl.branch_type = isa_pkg::BR_GE;
                    3'b110:  ctrl.branch_type = isa_pkg::BR_LTU;
                    3'b111:  ctrl.branch_type = isa_pkg::BR_GEU;
                    default: ctrl.branch_type = isa_pkg::BR_NONE;
                endcase
            end
            isa_pkg::OP_LOAD, isa_pkg::OP_STORE: begin
                ctrl.alu_src2_imm = 1'b1;  // Address is rs1 + imm
                ctrl.mem_read     = (inst.r.opcode == isa_pkg::OP_LOAD);
                ctrl.mem_write    = (inst.r.opcode == isa_pkg::OP_STORE);
                ctrl.reg_write    = (inst.r.opcode == isa_pkg::OP_LOAD);
                ctrl.mem_unsigned = (inst.r.opcode == isa_pkg::OP_LOAD) && inst.i.funct3[2];
                case (inst.i.funct3[1:0])
                    2'b00:   ctrl.mem_width = isa_pkg::MEM_BYTE;
                    2'b01:   ctrl.mem_width = isa_pkg::MEM_HALF;
                    default: ctrl.mem_width = isa_pkg::MEM_WORD;
                endcase
            end
            isa_pkg::OP_IMM, isa_pkg::OP_REG: begin
                ctrl.alu_src2_imm = (inst.r.opcode == isa_pkg::OP_IMM);
                ctrl.reg_write    = 1'b1;
                case (inst.r.funct3)
                    3'b000: begin
                        // SUB exists only in the register form
                        if (inst.r.opcode == isa_pkg::OP_REG && inst.r.funct7[5])
                            ctrl.alu_op = isa_pkg::ALU_SUB;
                        else
                            ctrl.alu_op = isa_pkg::ALU_ADD;
                    end
                    3'b001:  ctrl.alu_op = isa_pkg::ALU_SLL;
                    3'b010:  ctrl.alu_op = isa_pkg::ALU_SLT;
                    3'b011:  ctrl.alu_op = isa_pkg::ALU_SLTU;
                    3'b100:  ctrl.alu_op = isa_pkg::ALU_XOR;
                    3'b101:  ctrl.alu_op = inst.r.funct7[5] ? isa_pkg::ALU_SRA
                                                            : isa_pkg::ALU_SRL;
                    3'b110:  ctrl.alu_op = isa_pkg::ALU_OR;
                    default: ctrl.alu_op = isa_pkg::ALU_AND;
                endcase
            end
            default: ctrl.is_illegal = 1'b1;
        endcase
    end

    // Bundle for the output register
    always_comb begin
        next_id                  = '0;
        next_id.pc               = slot_data.pc;
        next_id.rs1_data         = rd_data.rs1_data;
        next_id.rs2_data         = rd_data.rs2_data;
        next_id.imm              = imm;
        next_id.rd               = inst.r.rd;
        next_id.rs1              = inst.r.rs1;
        next_id.rs2              = inst.r.rs2;
        next_id.prediction_valid = slot_data.prediction_valid;
        next_id.predicted_pc     = slot_data.predicted_pc;
        next_id.ctrl             = ctrl;
    end

endmodule

// File: design/isa_pkg.sv
`include "rv_id_cfg.svh"

package isa_pkg;

    // ------------------------------
    // Major opcodes kept in this core
    // ------------------------------
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_e;

    typedef enum logic [1:0] {
        MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_width_e;

    // Instruction layouts, msb first
    typedef struct packed {
        logic [6:0]           funct7;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [`RV_REG_W-1:0] rd;
        opcode_e              opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]          imm;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [`RV_REG_W-1:0] rd;
        opcode_e              opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]           imm_hi;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [4:0]           imm_lo;
        opcode_e              opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                 imm12;
        logic [5:0]           imm10_5;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [3:0]           imm4_1;
        logic                 imm11;
        opcode_e              opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]          imm;
        logic [`RV_REG_W-1:0] rd;
        opcode_e              opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                 imm20;
        logic [9:0]           imm10_1;
        logic                 imm11;
        logic [7:0]           imm19_12;
        logic [`RV_REG_W-1:0] rd;
        opcode_e              opcode;
    } j_fmt_t;

    // Same word, viewed per format
    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
        logic [31:0] raw;
    } inst_u;

    // Branch offset, shared by decode and early resolution
    function automatic logic [`RV_XLEN-1:0] imm_b(input inst_u inst);
        return {{(`RV_XLEN-12){inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
                inst.b.imm4_1, 1'b0};
    endfunction

endpackage

// File: design/pipe_pkg.sv
`include "rv_id_cfg.svh"

package pipe_pkg;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        isa_pkg::inst_u      inst;
        logic                prediction_valid;
        logic [`RV_XLEN-1:0] predicted_pc;
    } fetch_t;

    typedef struct packed {
        logic                 en;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_XLEN-1:0]  data;
    } wb_t;

    typedef struct packed {
        logic [`RV_REG_W-1:0] rs1;
        logic [`RV_REG_W-1:0] rs2;
    } rd_req_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
    } rd_data_t;

    // ------------------------------
    // Control bundle for execute
    // ------------------------------
    typedef struct packed {
        isa_pkg::alu_op_e    alu_op;
        logic                alu_src1_pc;   // Operand a is pc
        logic                alu_src2_imm;  // Operand b is imm
        logic                reg_write;
        logic                mem_read;
        logic                mem_write;
        isa_pkg::mem_width_e mem_width;
        logic                mem_unsigned;
        logic                is_branch;
        logic                is_jump;
        isa_pkg::branch_e    branch_type;
        logic                is_illegal;
    } ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  rs1_data;
        logic [`RV_XLEN-1:0]  rs2_data;
        logic [`RV_XLEN-1:0]  imm;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_REG_W-1:0] rs1;
        logic [`RV_REG_W-1:0] rs2;
        logic                 prediction_valid;
        logic [`RV_XLEN-1:0]  predicted_pc;
        ctrl_t                ctrl;
    } id_ex_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] target;
    } redirect_t;

endpackage

// File: design/reg_file.sv
`timescale 1ns/100ps
`include "rv_id_cfg.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  pipe_pkg::wb_t      wb,
    input  pipe_pkg::rd_req_t  rd_req,
    output pipe_pkg::rd_data_t rd_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // ------------------------------
    // Write port
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // ------------------------------
    // Read ports, x0 then bypass
    // ------------------------------
    always_comb begin
        if (rd_req.rs1 == '0)
            rd_data.rs1_data = '0;
        else if (wb.en && wb.rd == rd_req.rs1)
            rd_data.rs1_data = wb.data;  // Same-cycle write-back
        else
            rd_data.rs1_data = regs[rd_req.rs1];

        if (rd_req.rs2 == '0)
            rd_data.rs2_data = '0;
        else if (wb.en && wb.rd == rd_req.rs2)
            rd_data.rs2_data = wb.data;
        else
            rd_data.rs2_data = regs[rd_req.rs2];
    end

endmodule

// File: design/rv_id_cfg.svh
`ifndef RV_ID_CFG_SVH
`define RV_ID_CFG_SVH

// ------------------------------
// RV32I decode stage sizing
// ------------------------------

`define RV_XLEN    32  // Data and pc width
`define RV_NREGS   32  // Architectural registers
`define RV_REG_W   5   // Register index width
`define RV_PC_STEP 4   // Fall-through increment

`endif

// File: dv/id_ref.svh
`ifndef ID_REF_SVH
`define ID_REF_SVH

// ------------------------------
// Stimulus source
// ------------------------------

// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v          = {v[30:0], fb};
    end
    return v;
endfunction

function automatic pipe_pkg::fetch_t make_fetch();
    pipe_pkg::fetch_t f;
    logic [6:0]       op;
    logic [31:0]      tmp;
    case (lfsr_bits(4) % 10)
        0:       op = isa_pkg::OP_LUI;
        1:       op = isa_pkg::OP_AUIPC;
        2:       op = isa_pkg::OP_JAL;
        3:       op = isa_pkg::OP_JALR;
        4:       op = isa_pkg::OP_BRANCH;
        5:       op = isa_pkg::OP_LOAD;
        6:       op = isa_pkg::OP_STORE;
        7:       op = isa_pkg::OP_IMM;
        8:       op = isa_pkg::OP_REG;
        default: op = {2'(lfsr_bits(2)), 5'b11011};  // Never a kept opcode
    endcase
    tmp                = lfsr_bits(25);
    f.inst.raw         = {tmp[24:0], op};
    tmp                = lfsr_bits(30);
    f.pc               = {tmp[29:0], 2'b00};
    f.prediction_valid = 1'(lfsr_bits(1));
    tmp                = lfsr_bits(30);
    f.predicted_pc     = {tmp[29:0], 2'b00};
    return f;
endfunction

function automatic logic [31:0] branch_target(input pipe_pkg::fetch_t f);
    logic [31:0] w;
    w = f.inst.raw;
    return f.pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
endfunction

// ------------------------------
// Expected decode from the RV32I encoding
// ------------------------------
function automatic void ref_decode(input pipe_pkg::fetch_t f,
                                   output pipe_pkg::id_ex_t e,
                                   output pipe_pkg::redirect_t r);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    logic        taken;
    w                  = f.inst.raw;
    f3                 = w[14:12];
    a                  = model_regs[w[19:15]];
    b                  = model_regs[w[24:20]];
    taken              = 1'b0;
    e                  = '0;
    r                  = '0;
    e.pc               = f.pc;
    e.rs1_data         = a;
    e.rs2_data         = b;
    e.rd               = w[11:7];
    e.rs1              = w[19:15];
    e.rs2              = w[24:20];
    e.prediction_valid = f.prediction_valid;
    e.predicted_pc     = f.predicted_pc;
    case (w[6:0])
        isa_pkg::OP_LUI, isa_pkg::OP_AUIPC: begin
            e.imm               = {w[31:12], 12'b0};
            e.ctrl.alu_src1_pc  = (w[6:0] == isa_pkg::OP_AUIPC);
            e.ctrl.alu_src2_imm = 1'b1;
            e.ctrl.reg_write    = 1'b1;
            e.ctrl.alu_op       = (w[6:0] == isa_pkg::OP_LUI) ? isa_pkg::ALU_LUI
                                                              : isa_pkg::ALU_AUIPC;
        end
        isa_pkg::OP_JAL: begin
            e.imm               = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            e.ctrl.alu_src1_pc  = 1'b1;
            e.ctrl.alu_src2_imm = 1'b1;
            e.ctrl.is_jump      = 1'b1;
            e.ctrl.reg_write    = 1'b1;
        end
        isa_pkg::OP_JALR: begin
            e.imm               = {{20{w[31]}}, w[31:20]};
            e.ctrl.alu_src2_imm = 1'b1;
            e.ctrl.is_jump      = 1'b1;
            e.ctrl.reg_write    = 1'b1;
        end
        isa_pkg::OP_BRANCH: begin
            e.imm               = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            e.ctrl.alu_src1_pc  = 1'b1;
            e.ctrl.alu_src2_imm = 1'b1;
            e.ctrl.is_branch    = 1'b1;
            case (f3)
                3'b000:  e.ctrl.branch_type = isa_pkg::BR_EQ;
                3'b001:  e.ctrl.branch_type = isa_pkg::BR_NE;
                3'b100:  e.ctrl.branch_type = isa_pkg::BR_LT;
                3'b101:  e.ctrl.branch_type = isa_pkg::BR_GE;
                3'b110:  e.ctrl.branch_type = isa_pkg::BR_LTU;
                3'b111:  e.ctrl.branch_type = isa_pkg::BR_GEU;
                default: e.ctrl.branch_type = isa_pkg::BR_NONE;
            endcase
            case (f3)
                3'b000:  taken = (a == b);
                3'b001:  taken = (a != b);
                3'b100:  taken = ($signed(a) < $signed(b));
                3'b101:  taken = ($signed(a) >= $signed(b));
                3'b110:  taken = (a < b);
                3'b111:  taken = (a >= b);
                default: taken = 1'b0;
            endcase
            // Misprediction table
            if (taken && (!f.prediction_valid || f.predicted_pc != branch_target(f))) begin
                r.valid  = 1'b1;
                r.target = branch_target(f);
            end else if (!taken && f.prediction_valid) begin
                r.valid  = 1'b1;
                r.target = f.pc + `RV_PC_STEP;
            end
        end
        isa_pkg::OP_LOAD, isa_pkg::OP_STORE: begin
            if (w[6:0] == isa_pkg::OP_LOAD) begin
                e.imm               = {{20{w[31]}}, w[31:20]};
                e.ctrl.mem_read     = 1'b1;
                e.ctrl.reg_write    = 1'b1;
                e.ctrl.mem_unsigned = f3[2];
            end else begin
                e.imm            = {{20{w[31]}}, w[31:25], w[11:7]};
                e.ctrl.mem_write = 1'b1;
            end
            e.ctrl.alu_src2_imm = 1'b1;
            if (f3[1:0] == 2'b00)
                e.ctrl.mem_width = isa_pkg::MEM_BYTE;
            else if (f3[1:0] == 2'b01)
                e.ctrl.mem_width = isa_pkg::MEM_HALF;
            else
                e.ctrl.mem_width = isa_pkg::MEM_WORD;
        end
        isa_pkg::OP_IMM, isa_pkg::OP_REG: begin
            if (w[6:0] == isa_pkg::OP_IMM) begin
                e.imm               = {{20{w[31]}}, w[31:20]};
                e.ctrl.alu_src2_imm = 1'b1;
            end
            e.ctrl.reg_write = 1'b1;
            case (f3)
                3'b000:  e.ctrl.alu_op = (w[6:0] == isa_pkg::OP_REG && w[30])
                                         ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
                3'b001:  e.ctrl.alu_op = isa_pkg::ALU_SLL;
                3'b010:  e.ctrl.alu_op = isa_pkg::ALU_SLT;
                3'b011:  e.ctrl.alu_op = isa_pkg::ALU_SLTU;
                3'b100:  e.ctrl.alu_op = isa_pkg::ALU_XOR;
                3'b101:  e.ctrl.alu_op = w[30] ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
                3'b110:  e.ctrl.alu_op = isa_pkg::ALU_OR;
                default: e.ctrl.alu_op = isa_pkg::ALU_AND;
            endcase
        end
        default: e.ctrl.is_illegal = 1'b1;
    endcase
endfunction

// ------------------------------
// Compare tasks
// ------------------------------
task automatic check_id_ex(input string name, input pipe_pkg::id_ex_t exp,
                           input pipe_pkg::id_ex_t act);
    if (act !== exp) begin
        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        stop_run();
    end
endtask

// Target only matters with valid set
task automatic check_redirect(input string name, input pipe_pkg::redirect_t exp,
                              input pipe_pkg::redirect_t act);
    if (act.valid !== exp.valid || (exp.valid && act.target !== exp.target)) begin
        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
        stop_run();
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
        stop_run();
    end
endtask

`endif

// File: dv/id_stage_tb.sv
`timescale 1ns/100ps
`include "rv_id_cfg.svh"

module id_stage_tb;

    localparam int RESET_CYCLES = 16;
    localparam int N_ITEMS      = 16 + 40 + 8 + 48 + 150;

    logic                clk;
    logic                rst;
    logic                flush;
    logic                in_valid;
    pipe_pkg::fetch_t    in_data;
    logic                in_ready;
    pipe_pkg::wb_t       wb;
    logic                out_valid;
    pipe_pkg::id_ex_t    out_data;
    logic                out_ready;
    pipe_pkg::redirect_t redirect;

    logic [`RV_XLEN-1:0] model_regs [`RV_NREGS];  // Register file as the TB sees it
    logic [31:0]         lfsr_state;
    logic                rand_ready;                // out_ready from the LFSR
    logic                lat_on;                    // Items timed against fixed latency
    int                  cycle;
    int                  n_out;

    pipe_pkg::id_ex_t    exp_id_q [$];
    pipe_pkg::redirect_t exp_rd_q [$];
    int                  exp_cyc_q [$];

    logic                prev_valid;
    logic                prev_ready;
    pipe_pkg::id_ex_t    prev_data;

    id_stage dut_i (
        .clk, .rst, .flush, .in_valid, .in_data, .in_ready, .wb,
        .out_valid, .out_data, .out_ready, .redirect
    );

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    `include "id_ref.svh"

    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (rand_ready)
            out_ready = 1'(lfsr_bits(1));
        else
            out_ready = 1'b1;
    end

    task automatic send_item(input pipe_pkg::fetch_t f);
        @(negedge clk);
        in_valid = 1'b1;
        in_data  = f;
        @(posedge clk);
        while (!in_ready) begin
            if (lat_on) begin
                $display("in_ready fell while out_ready was held high");
                stop_run();
            end
            @(posedge clk);
        end
    endtask

    task automatic drain();
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_id_q.size() != 0)
            @(negedge clk);
        @(posedge clk);
    endtask

    // ------------------------------
    // Scoreboard and comparison
    // ------------------------------
    always @(posedge clk) begin : scoreboard
        pipe_pkg::id_ex_t    exp_e;
        pipe_pkg::redirect_t exp_r;
        pipe_pkg::redirect_t quiet;
        logic                is_new;
        int                  t_in;
        quiet = '0;
        if (rst) begin
            prev_valid = 1'b0;
            prev_ready = 1'b0;
        end else begin
            cycle++;
            if (out_valid && exp_id_q.size() == 0) begin
                $display("out_valid high at %0t with no item pending", $time);
                stop_run();
            end
            if (prev_valid && !prev_ready) begin  // Held under back-pressure
                check_bit("out_valid", 1'b1, out_valid);
                check_id_ex("out_data held", prev_data, out_data);
            end
            is_new = out_valid && (!prev_valid || prev_ready);
            if (is_new)
                check_redirect("redirect", exp_rd_q[0], redirect);
            else
                check_redirect("redirect", quiet, redirect);
            if (out_valid && out_ready) begin
                exp_e = exp_id_q.pop_front();
                exp_r = exp_rd_q.pop_front();
                t_in  = exp_cyc_q.pop_front();
                check_id_ex("out_data", exp_e, out_data);
                if (t_in >= 0 && cycle - t_in != 2) begin
                    $display("latency of %0d edges instead of 2 at %0t", cycle - t_in, $time);
                    stop_run();
                end
                n_out++;
            end
            if (in_valid && in_ready) begin
                ref_decode(in_data, exp_e, exp_r);
                exp_id_q.push_back(exp_e);
                exp_rd_q.push_back(exp_r);
                exp_cyc_q.push_back(lat_on ? cycle : -1);
            end
            prev_valid = out_valid;
            prev_ready = out_ready;
            prev_data  = out_data;
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin : main
        pipe_pkg::fetch_t f;
        logic [31:0]      d;
        logic [4:0]       r;
        clk        = 1'b0;
        rst        = 1'b1;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        wb         = '0;
        out_ready  = 1'b1;
        lfsr_state = 32'h8ecf33a7;
        rand_ready = 1'b0;
        lat_on     = 1'b0;
        cycle      = 0;
        n_out      = 0;
        for (int i = 0; i < `RV_NREGS; i++)
            model_regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("redirect.valid", 1'b0, redirect.valid);
        check_bit("in_ready", 1'b1, in_ready);

        // Every register reads zero while x0 is being written
        @(negedge clk);
        wb.en   = 1'b1;
        wb.rd   = '0;
        wb.data = 32'h5a5aa5a5;
        for (int i = 0; i < 16; i++) begin
            f                 = make_fetch();
            f.inst.raw[19:15] = 5'(2 * i);
            f.inst.raw[24:20] = 5'(2 * i + 1);
            send_item(f);
        end
        drain();
        @(negedge clk);
        wb.en = 1'b0;

        // Preload with the pipe empty
        for (int i = 0; i < `RV_NREGS; i++) begin
            d = lfsr_bits(32);
            @(negedge clk);
            wb.en   = 1'b1;
            wb.rd   = 5'(i);
            wb.data = d;
            if (i != 0)
                model_regs[i] = d;
        end
        @(negedge clk);
        wb.en = 1'b0;

        lat_on = 1'b1;
        for (int i = 0; i < 40; i++)
            send_item(make_fetch());
        drain();
        lat_on = 1'b0;

        // Write-back lands while the item sits in the slot
        for (int i = 0; i < 8; i++) begin
            f = make_fetch();
            r = f.inst.r.rs1;
            if (r == '0)
                r = 5'd1;
            f.inst.raw[19:15] = r;
            d                 = lfsr_bits(32);
            model_regs[r]     = d;
            send_item(f);
            @(negedge clk);
            in_valid = 1'b0;
            wb.en    = 1'b1;
            wb.rd    = r;
            wb.data  = d;
            @(negedge clk);
            wb.en = 1'b0;
            drain();
        end

        // Six conditions by four prediction cases on equal and unequal operands
        rand_ready = 1'b1;
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 4; p++) begin
                for (int q = 0; q < 2; q++) begin
                    f                 = make_fetch();
                    f.inst.raw[6:0]   = isa_pkg::OP_BRANCH;
                    f.inst.raw[14:12] = (c < 2) ? 3'(c) : 3'(c + 2);
                    if (q == 1)
                        f.inst.raw[24:20] = f.inst.raw[19:15];
                    f.prediction_valid = (p != 0);
                    if (p == 1)
                        f.predicted_pc = branch_target(f);
                    else if (p == 2)
                        f.predicted_pc = branch_target(f) + 32'd8;
                    else
                        f.predicted_pc = f.pc + `RV_PC_STEP;
                    send_item(f);
                end
            end
        end
        drain();

        for (int i = 0; i < 150; i++) begin
            f = make_fetch();
            if (2'(lfsr_bits(2)) == 2'b00) begin
                @(negedge clk);
                in_valid = 1'b0;  // Idle gap
            end
            send_item(f);
        end
        drain();
        rand_ready = 1'b0;

        if (n_out == N_ITEMS) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("%0d items came out but %0d were sent", n_out, N_ITEMS);
            stop_run();
        end
    end

    initial begin : watchdog
        #((N_ITEMS * 20 + RESET_CYCLES) * 10);
        $display("timeout, outputs stopped arriving");
        stop_run();
    end

endmodule

// File: project.f
+incdir+design
+incdir+dv
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_slot.sv
design/reg_file.sv
design/inst_decoder.sv
design/branch_resolver.sv
design/decode_out_reg.sv
design/id_stage.sv
dv/id_stage_tb.sv
